/* filelist.f */
common/icache_types_pkg.sv
common/icache_ctrl_pkg.sv
icache/icache_control.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
source/icache_top.sv
verification/icache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/icache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

  import icache_types_pkg::*;

  localparam int num_fetches = 400;
  localparam int cycle_limit = num_fetches * 12 + 1200;

  logic     clk = 1'b0;
  logic     rst;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  int       seed;
  int       cycle_count = 0;

  // reference cache state
  logic [tag_width-1:0] model_tag   [num_sets][num_ways];
  logic                 model_valid [num_sets][num_ways];
  logic                 model_lru   [num_sets];

  icache_top uut (
    .clk     (clk),
    .rst     (rst),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit)
      report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  // memory contents, one word per word address
  function automatic logic [word_width-1:0] mix_word(input logic [addr_width-3:0] word_addr);
    logic [word_width-1:0] x;
    x = {2'b00, word_addr} * 32'h9e37_79b1;
    return x ^ (x >> 13) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [line_width-1:0] make_line(input logic [addr_width-1:0] addr);
    logic [line_width-1:0] line;
    for (int i = 0; i < words_per_line; i++)
      line[i*word_width +: word_width] = mix_word({addr[addr_width-1:offset_width], i[2:0]});
    return line;
  endfunction

  // small tag pool so lines get evicted and fetched again
  function automatic logic [addr_width-1:0] pick_address();
    logic [tag_width-1:0] pool [4] = '{24'h00_0040, 24'h12_3456, 24'h0a_bc00, 24'hff_0001};
    int r;
    r = $random(seed);
    return {pool[r[1:0]], r[4:2], r[7:5], 2'b00};
  endfunction

  task automatic check_word(input cpu_rsp_t expected, input cpu_rsp_t actual);
    if (actual !== expected)
      report_failure($sformatf(
          "Fail at %0t: cpu_rsp expected resp=%b rdata=%h, got resp=%b rdata=%h",
          $time, expected.resp, expected.rdata, actual.resp, actual.rdata));
  endtask

  task automatic check_mem_req(input mem_req_t expected, input mem_req_t actual);
    if (actual !== expected)
      report_failure($sformatf(
          "Fail at %0t: mem_req expected read=%b address=%h, got read=%b address=%h",
          $time, expected.read, expected.address, actual.read, actual.address));
  endtask

  // read low for a few cycles, nothing may come out
  task automatic pause_read(input int cycles);
    @(posedge clk);
    cpu_req.read <= 1'b0;
    repeat (cycles)
    begin
      @(negedge clk);
      if (cpu_rsp.resp !== 1'b0 || mem_req.read !== 1'b0)
        report_failure($sformatf("Fail at %0t: cpu_rsp.resp/mem_req.read expected 0/0, got %b/%b",
                                 $time, cpu_rsp.resp, mem_req.read));
    end
  endtask

  // one fetch, also answering line requests as the memory
  task automatic fetch(input logic [addr_width-1:0] addr);
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] set_idx;
    logic                   hit_way;
    logic                   victim;
    bit                     predict_hit;
    bit                     waiting;
    bit                     answered;
    bit                     done;
    int                     mem_reads;
    int                     wait_left;
    cpu_rsp_t               exp_rsp;
    mem_req_t               exp_req;
    tag = addr[addr_width-1 -: tag_width];
    set_idx = addr[offset_width +: index_width];
    predict_hit = 1'b0;
    hit_way = 1'b0;
    for (int w = 0; w < num_ways; w++)
    begin
      if (model_valid[set_idx][w[0]] && model_tag[set_idx][w[0]] == tag)
      begin
        predict_hit = 1'b1;
        hit_way = w[0];
      end
    end
    exp_rsp = '{resp: 1'b1, rdata: mix_word(addr[addr_width-1:2])};
    // byte address of the first byte in the line
    exp_req = '{read: 1'b1, address: addr & ~addr_width'(line_width / 8 - 1)};
    waiting = 1'b0;
    answered = 1'b0;
    done = 1'b0;
    mem_reads = 0;
    wait_left = 0;
    @(posedge clk);
    cpu_req <= '{read: 1'b1, address: addr};
    while (!done)
    begin
      @(negedge clk);
      if (cpu_rsp.resp)
      begin
        check_word(exp_rsp, cpu_rsp);
        done = 1'b1;
      end
      // line lands in this cycle, read is still high
      else if (answered)
        answered = 1'b0;
      else if (mem_req.read)
      begin
        check_mem_req(exp_req, mem_req);
        if (!waiting)
        begin
          mem_reads++;
          waiting = 1'b1;
          wait_left = 1 + ($random(seed) & 3);
        end
      end
      else if (waiting)
        report_failure("mem_req.read dropped before the memory answered");
      if (!done)
      begin
        @(posedge clk);
        mem_rsp.resp <= 1'b0;
        wait_left--;
        if (waiting && wait_left == 0)
        begin
          mem_rsp <= '{resp: 1'b1, rdata: make_line(addr)};
          waiting = 1'b0;
          answered = 1'b1;
        end
      end
    end
    if (predict_hit && mem_reads != 0)
      report_failure("model predicted a hit, but the DUT requested a line from memory");
    if (!predict_hit && mem_reads != 1)
      report_failure($sformatf("model predicted a miss, but the DUT made %0d line requests",
                               mem_reads));
    // way just used becomes most recent
    if (predict_hit)
      model_lru[set_idx] = ~hit_way;
    else
    begin
      victim = model_lru[set_idx];
      model_tag[set_idx][victim] = tag;
      model_valid[set_idx][victim] = 1'b1;
      model_lru[set_idx] = ~victim;
    end
  endtask

  initial
  begin
    seed = 32'habc2_2214;
    rst = 1'b1;
    cpu_req = '0;
    mem_rsp = '0;
    foreach (model_valid[s, w])
      model_valid[s][w] = 1'b0;
    foreach (model_lru[s])
      model_lru[s] = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    pause_read(4);
    // third tag in set 3 evicts the oldest, then both old tags come back
    fetch({24'h0d_0001, 3'd3, 3'd1, 2'b00});
    fetch({24'h0d_0002, 3'd3, 3'd4, 2'b00});
    fetch({24'h0d_0003, 3'd3, 3'd7, 2'b00});
    fetch({24'h0d_0002, 3'd3, 3'd0, 2'b00});
    fetch({24'h0d_0001, 3'd3, 3'd2, 2'b00});
    for (int n = 0; n < num_fetches; n++)
    begin
      fetch(pick_address());
      if (($random(seed) & 3) == 0)
        pause_read(1 + ($random(seed) & 1));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_top (
  input  logic                       clk,
  input  logic                       rst,
  input  icache_types_pkg::cpu_req_t cpu_req,
  output icache_types_pkg::cpu_rsp_t cpu_rsp,
  output icache_types_pkg::mem_req_t mem_req,
  input  icache_types_pkg::mem_rsp_t mem_rsp
);

  import icache_types_pkg::*;
  import icache_ctrl_pkg::*;

  lookup_t               lookup;
  array_ctrl_t           ctrl;
  logic                  cpu_resp;
  logic                  mem_read;
  logic [word_width-1:0] rdata;

  icache_control u_control (
    .clk      (clk),
    .rst      (rst),
    .cpu_read (cpu_req.read),
    .lookup   (lookup),
    .mem_resp (mem_rsp.resp),
    .ctrl     (ctrl),
    .mem_read (mem_read),
    .cpu_resp (cpu_resp)
  );

  icache_tag_array u_tag_array (
    .clk     (clk),
    .rst     (rst),
    .address (cpu_req.address),
    .ctrl    (ctrl),
    .lookup  (lookup)
  );

  icache_data_array u_data_array (
    .clk       (clk),
    .address   (cpu_req.address),
    .fill_line (mem_rsp.rdata),
    .lookup    (lookup),
    .ctrl      (ctrl),
    .rdata     (rdata)
  );

  assign cpu_rsp.resp   = cpu_resp;
  assign cpu_rsp.rdata  = rdata;
  assign mem_req.read   = mem_read;
  // line aligned fetch address
  assign mem_req.address = {cpu_req.address[addr_width-1:offset_width], {offset_width{1'b0}}};

endmodule

`default_nettype wire

/* icache/icache_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_data_array (
  input  logic                                    clk,
  input  logic [icache_types_pkg::addr_width-1:0] address,
  input  logic [icache_types_pkg::line_width-1:0] fill_line,
  input  icache_types_pkg::lookup_t               lookup,
  input  icache_ctrl_pkg::array_ctrl_t            ctrl,
  output logic [icache_types_pkg::word_width-1:0] rdata
);

  import icache_types_pkg::*;
  import icache_ctrl_pkg::*;

  logic [line_width-1:0]     lines [num_ways][num_sets];
  logic [index_width-1:0]    index;
  logic [offset_width-3:0]   word_sel;
  logic [line_width-1:0]     hit_line;

  assign index    = address[offset_width +: index_width];
  // byte offset minus the two bits inside a word
  assign word_sel = address[offset_width-1:2];

  // line is written into the victim way as memory answers
  always_ff @(posedge clk)
  begin
    if (ctrl.write_status == WS_FILL)
    begin
      lines[lookup.lru_way][index] <= fill_line;
    end
  end

  assign hit_line = lines[lookup.way_hit][index];
  assign rdata    = hit_line[word_sel*word_width +: word_width];

endmodule

`default_nettype wire

/* icache/icache_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [icache_types_pkg::addr_width-1:0]    address,
  input  icache_ctrl_pkg::array_ctrl_t               ctrl,
  output icache_types_pkg::lookup_t                  lookup
);

  import icache_types_pkg::*;

  logic [tag_width-1:0]   addr_tag;
  logic [index_width-1:0] index;

  logic [tag_width-1:0]               tags [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0]  valid;
  logic [num_sets-1:0]                lru;
  logic [num_ways-1:0]                way_match;

  assign addr_tag = address[addr_width-1 -: tag_width];
  assign index    = address[offset_width +: index_width];

  // tags only count once valid is set
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      if (ctrl.load_tag[w])
        tags[w][index] <= addr_tag;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid <= '0;
      lru   <= '0;
    end
    else
    begin
      for (int w = 0; w < num_ways; w++)
      begin
        if (ctrl.load_valid[w])
          valid[w][index] <= ctrl.valid_in;
      end
      if (ctrl.load_lru)
        lru[index] <= ctrl.lru_value;
    end
  end

  // compare both ways of the indexed set
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      way_match[w] = valid[w][index] && (tags[w][index] == addr_tag);
    end
  end

  assign lookup.hit     = |way_match;
  assign lookup.way_hit = way_match[1];
  assign lookup.lru_way = lru[index];

  // fills always go to a missing tag, so one line never sits in both ways
  assert property (@(posedge clk) disable iff (rst)
    !(valid[0][index] && valid[1][index] && (tags[0][index] == tags[1][index])));

endmodule

`default_nettype wire

/* icache/icache_control.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_control (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cpu_read,
  input  icache_types_pkg::lookup_t     lookup,
  input  logic                          mem_resp,
  output icache_ctrl_pkg::array_ctrl_t  ctrl,
  output logic                          mem_read,
  output logic                          cpu_resp
);

  import icache_ctrl_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  // next state
  always_comb
  begin
    next_state = state;
    unique case (state)
      IDLE:
      begin
        if (cpu_read)
          next_state = CHECK;
      end
      CHECK:
      begin
        if (!cpu_read)
          next_state = IDLE;
        else if (!lookup.hit)
          next_state = FILL;
        else
          next_state = CHECK;
      end
      FILL:
      begin
        // line lands this cycle, lookup hits next cycle
        if (mem_resp)
          next_state = CHECK;
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // outputs, all strobes low unless a state raises them
  always_comb
  begin
    ctrl.load_tag     = 2'b00;
    ctrl.load_valid   = 2'b00;
    ctrl.valid_in     = 1'b0;
    ctrl.load_lru     = 1'b0;
    ctrl.lru_value    = 1'b0;
    ctrl.write_status = WS_NONE;
    mem_read          = 1'b0;
    cpu_resp          = 1'b0;
    unique case (state)
      CHECK:
      begin
        if (cpu_read && lookup.hit)
        begin
          cpu_resp       = 1'b1;
          ctrl.load_lru  = 1'b1;
          // the way not used becomes the victim
          ctrl.lru_value = ~lookup.way_hit;
        end
      end
      FILL:
      begin
        mem_read = 1'b1;
        if (mem_resp)
        begin
          ctrl.write_status               = WS_FILL;
          ctrl.load_tag[lookup.lru_way]   = 1'b1;
          ctrl.load_valid[lookup.lru_way] = 1'b1;
          ctrl.valid_in                   = 1'b1;
        end
        else
        begin
          ctrl.write_status = WS_FETCH;
        end
      end
      default:
      begin
      end
    endcase
  end

  // a word goes out only in CHECK, never in the cycle a read first appears
  assert property (@(posedge clk) disable iff (rst)
    cpu_resp |-> (state == CHECK) && $past(cpu_read));

  // a fill writes one way only
  assert property (@(posedge clk) disable iff (rst)
    $onehot0(ctrl.load_tag));

  // memory request is a level until the line arrives
  assert property (@(posedge clk) disable iff (rst)
    mem_read && !mem_resp |=> mem_read);

endmodule

`default_nettype wire

/* common/icache_ctrl_pkg.sv */
`default_nettype none

package icache_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    CHECK = 2'b01,
    FILL  = 2'b10
  } ctrl_state_e;

  // what the arrays are busy with
  typedef enum logic [1:0] {
    WS_NONE  = 2'b00,
    WS_FETCH = 2'b01,
    WS_FILL  = 2'b10
  } write_status_e;

  typedef struct packed {
    logic [1:0]    load_tag;
    logic [1:0]    load_valid;
    logic          valid_in;
    logic          load_lru;
    logic          lru_value;
    write_status_e write_status;
  } array_ctrl_t;

endpackage

`default_nettype wire

/* common/icache_types_pkg.sv */
`default_nettype none

package icache_types_pkg;

  // address split: tag | index | byte offset
  localparam int addr_width     = 32;
  localparam int word_width     = 32;
  localparam int words_per_line = 8;
  localparam int line_width     = word_width * words_per_line;
  localparam int offset_width   = 5;
  localparam int index_width    = 3;
  localparam int num_sets       = 1 << index_width;
  localparam int tag_width      = addr_width - index_width - offset_width;
  localparam int num_ways       = 2;

  // fetch port
  typedef struct packed {
    logic                  read;
    logic [addr_width-1:0] address;
  } cpu_req_t;

  typedef struct packed {
    logic                  resp;
    logic [word_width-1:0] rdata;
  } cpu_rsp_t;

  // line-wide memory port, address always line aligned
  typedef struct packed {
    logic                  read;
    logic [addr_width-1:0] address;
  } mem_req_t;

  typedef struct packed {
    logic                  resp;
    logic [line_width-1:0] rdata;
  } mem_rsp_t;

  // result of one combinational lookup
  typedef struct packed {
    logic hit;
    logic way_hit;
    logic lru_way;
  } lookup_t;

endpackage

`default_nettype wire
